//--- src/core_pkg.sv
package core_pkg;

    // ******************************
    // Widths
    // ******************************

    // Register and packet data
    localparam int DATA_W  = 32;
    // Register file address, sixteen registers
    localparam int REG_AW  = 4;
    // Instruction memory address, 256 words
    localparam int PC_W    = 8;
    localparam int INSTR_W = 16;
    // Network core ID
    localparam int ID_W    = 4;

    // ******************************
    // Instruction fields
    // ******************************

    // Opcode in the top 4 bits
    localparam int OPC_LSB = 12;
    // Destination register below the opcode
    localparam int RD_LSB  = 8;
    // Low byte is rs (low nibble) or immediate / branch offset
    localparam int IMM_W   = 8;

    // Opcodes, encodings 10 to 15 are illegal
    typedef enum logic [3:0]
    {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_MOVI = 4'd5,
        OP_BEQZ = 4'd6,
        OP_BNEZ = 4'd7,
        OP_SW   = 4'd8,
        OP_WAIT = 4'd9
    } opcode_e;

    // Network packet operations
    typedef enum logic [1:0]
    {
        NET_NONE  = 2'd0,
        NET_PC    = 2'd1,
        NET_INSTR = 2'd2,
        NET_REG   = 2'd3
    } net_op_e;

    // Run state machine
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_ERR  = 2'd2
    } state_e;

endpackage

//--- src/core_ctrl.sv
module core_ctrl #(
    parameter logic [core_pkg::ID_W-1:0] CORE_ID = '0
)
(
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic [core_pkg::ID_W-1:0] net_id_i,
    input  core_pkg::net_op_e         net_op_i,
    input  logic                      wait_i,
    input  logic                      illegal_i,
    output logic                      run_o,
    output logic                      pc_load_o,
    output logic                      imem_wen_o,
    output logic                      net_rf_wen_o,
    output logic                      exception_o
);
    import core_pkg::*;

    state_e state_r;
    state_e state_n;
    logic   id_match;
    logic   net_pc;

    // Packet is addressed to this core
    assign id_match = (net_id_i == CORE_ID);
    assign net_pc   = id_match && (net_op_i == NET_PC);

    // Network strobes, honoured in IDLE only
    assign pc_load_o    = net_pc && (state_r == ST_IDLE);
    assign imem_wen_o   = id_match && (net_op_i == NET_INSTR) && (state_r == ST_IDLE);
    assign net_rf_wen_o = id_match && (net_op_i == NET_REG) && (state_r == ST_IDLE);

    // Pipeline advances only while staying in RUN
    // so a WAIT or a fault freezes fetch and flushes at this edge
    assign run_o = (state_r == ST_RUN) && (state_n == ST_RUN);

    // ******************************
    // Run state machine
    // ******************************

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            ST_IDLE:
            begin
                // PC packet starts the program
                if (net_pc)
                    state_n = ST_RUN;
            end
            ST_RUN:
            begin
                // PC packet while running is a protocol error
                if (illegal_i || net_pc)
                    state_n = ST_ERR;
                else if (wait_i)
                    state_n = ST_IDLE;
            end
            default:
            begin
                // ERR is sticky and ignores all packets
                state_n = ST_ERR;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= ST_IDLE;
            exception_o <= 1'b0;
        end
        else
        begin
            state_r <= state_n;
            // Exception held until reset
            if (state_n == ST_ERR)
                exception_o <= 1'b1;
        end
    end

endmodule

//--- src/fetch.sv
module fetch (
    input  logic                         clk,
    input  logic                         n_reset,
    input  logic                         run_i,
    input  logic                         pc_load_i,
    input  logic                         imem_wen_i,
    input  logic [core_pkg::PC_W-1:0]    net_addr_i,
    input  logic [core_pkg::DATA_W-1:0]  net_data_i,
    input  logic                         branch_i,
    input  logic [core_pkg::PC_W-1:0]    branch_target_i,
    output logic [core_pkg::INSTR_W-1:0] if_instr_o,
    output logic [core_pkg::PC_W-1:0]    if_pc_o
);
    import core_pkg::*;

    logic [PC_W-1:0]    pc_r;
    logic [PC_W-1:0]    pc_n;
    logic [INSTR_W-1:0] imem [2**PC_W];
    logic [INSTR_W-1:0] imem_rdata;

    // ******************************
    // Next PC
    // ******************************

    // Packet load wins, then a taken branch, then sequential fetch
    always_comb
    begin
        if (pc_load_i)
            pc_n = net_addr_i;
        else if (branch_i)
            pc_n = branch_target_i;
        else if (run_i)
            pc_n = pc_r + 1'b1;
        else
            pc_n = pc_r;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else
            pc_r <= pc_n;
    end

    // ******************************
    // Instruction memory
    // ******************************

    // Write port from the network
    // instructions sit in the low bits of the packet data
    always_ff @(posedge clk)
    begin
        if (imem_wen_i)
            imem[net_addr_i] <= net_data_i[INSTR_W-1:0];
    end

    // Synchronous read on the next PC
    // so imem_rdata always belongs to pc_r
    always_ff @(posedge clk)
    begin
        imem_rdata <= imem[pc_n];
    end

    // ******************************
    // IF/ID register
    // ******************************

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            if_instr_o <= {OP_NOP, OPC_LSB'(0)};
        else if (branch_i || !run_i)
            // Flushed slot becomes a NOP
            if_instr_o <= {OP_NOP, OPC_LSB'(0)};
        else
            if_instr_o <= imem_rdata;
    end

    // PC travels with the instruction for branch targets
    always_ff @(posedge clk)
    begin
        if_pc_o <= pc_r;
    end

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic                        clk,
    input  logic [core_pkg::REG_AW-1:0] rs_addr_i,
    input  logic [core_pkg::REG_AW-1:0] rd_addr_i,
    input  logic                        net_wen_i,
    input  logic [core_pkg::REG_AW-1:0] net_addr_i,
    input  logic [core_pkg::DATA_W-1:0] net_data_i,
    input  logic                        ex_wen_i,
    input  logic [core_pkg::REG_AW-1:0] ex_waddr_i,
    input  logic [core_pkg::DATA_W-1:0] ex_wdata_i,
    output logic [core_pkg::DATA_W-1:0] rs_val_o,
    output logic [core_pkg::DATA_W-1:0] rd_val_o
);
    import core_pkg::*;

    logic [DATA_W-1:0] regs [2**REG_AW];
    logic              wen;
    logic [REG_AW-1:0] waddr;
    logic [DATA_W-1:0] wdata;

    // Network writes only in IDLE, execute writes only in RUN
    assign wen   = net_wen_i || ex_wen_i;
    assign waddr = net_wen_i ? net_addr_i : ex_waddr_i;
    assign wdata = net_wen_i ? net_data_i : ex_wdata_i;

    always_ff @(posedge clk)
    begin
        if (wen)
            regs[waddr] <= wdata;
    end

    // r0 is hardwired to zero
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

//--- src/decode_stage.sv
module decode_stage (
    input  logic                         clk,
    input  logic                         n_reset,
    input  logic                         run_i,
    input  logic                         branch_i,
    input  logic [core_pkg::INSTR_W-1:0] if_instr_i,
    input  logic [core_pkg::PC_W-1:0]    if_pc_i,
    input  logic [core_pkg::DATA_W-1:0]  rs_val_i,
    input  logic [core_pkg::DATA_W-1:0]  rd_val_i,
    input  logic                         ex_wen_i,
    input  logic [core_pkg::REG_AW-1:0]  ex_waddr_i,
    input  logic [core_pkg::DATA_W-1:0]  ex_wdata_i,
    output logic [core_pkg::REG_AW-1:0]  rs_addr_o,
    output logic [core_pkg::REG_AW-1:0]  rd_addr_o,
    output logic [core_pkg::INSTR_W-1:0] id_instr_o,
    output logic [core_pkg::PC_W-1:0]    id_pc_o,
    output logic [core_pkg::DATA_W-1:0]  id_rs_val_o,
    output logic [core_pkg::DATA_W-1:0]  id_rd_val_o
);
    import core_pkg::*;

    logic              fwd_rs;
    logic              fwd_rd;
    logic [DATA_W-1:0] rs_val;
    logic [DATA_W-1:0] rd_val;

    // Read addresses straight from the instruction fields
    // rs is the low nibble of rs_imm
    assign rs_addr_o = if_instr_i[REG_AW-1:0];
    assign rd_addr_o = if_instr_i[RD_LSB +: REG_AW];

    // ******************************
    // Forwarding from execute
    // ******************************

    // Execute writes land at this edge, so bypass the stale read
    // r0 never forwards
    assign fwd_rs = ex_wen_i && (ex_waddr_i == rs_addr_o) && (rs_addr_o != '0);
    assign fwd_rd = ex_wen_i && (ex_waddr_i == rd_addr_o) && (rd_addr_o != '0);

    assign rs_val = fwd_rs ? ex_wdata_i : rs_val_i;
    assign rd_val = fwd_rd ? ex_wdata_i : rd_val_i;

    // ******************************
    // ID/EX register
    // ******************************

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            id_instr_o <= {OP_NOP, OPC_LSB'(0)};
        else if (branch_i || !run_i)
            id_instr_o <= {OP_NOP, OPC_LSB'(0)};
        else
            id_instr_o <= if_instr_i;
    end

    // Operands and PC are don't-care behind a NOP
    always_ff @(posedge clk)
    begin
        id_pc_o     <= if_pc_i;
        id_rs_val_o <= rs_val;
        id_rd_val_o <= rd_val;
    end

endmodule

//--- src/exec_stage.sv
module exec_stage (
    input  logic [core_pkg::INSTR_W-1:0] id_instr_i,
    input  logic [core_pkg::PC_W-1:0]    id_pc_i,
    input  logic [core_pkg::DATA_W-1:0]  id_rs_val_i,
    input  logic [core_pkg::DATA_W-1:0]  id_rd_val_i,
    output logic                         wen_o,
    output logic [core_pkg::REG_AW-1:0]  waddr_o,
    output logic [core_pkg::DATA_W-1:0]  wdata_o,
    output logic                         branch_o,
    output logic [core_pkg::PC_W-1:0]    branch_target_o,
    output logic                         store_o,
    output logic [core_pkg::DATA_W-1:0]  store_addr_o,
    output logic [core_pkg::DATA_W-1:0]  store_data_o,
    output logic                         wait_o,
    output logic                         illegal_o
);
    import core_pkg::*;

    opcode_e          opcode;
    logic [IMM_W-1:0] imm;

    assign opcode  = opcode_e'(id_instr_i[OPC_LSB +: $bits(opcode_e)]);
    assign imm     = id_instr_i[IMM_W-1:0];
    assign waddr_o = id_instr_i[RD_LSB +: REG_AW];

    // Branch target relative to the branch's own PC
    assign branch_target_o = id_pc_i + PC_W'($signed(imm));

    // SW: rd value stored at address held in rs
    assign store_addr_o = id_rs_val_i;
    assign store_data_o = id_rd_val_i;

    // ******************************
    // Opcode decode and ALU
    // ******************************

    always_comb
    begin
        wen_o     = 1'b0;
        wdata_o   = '0;
        branch_o  = 1'b0;
        store_o   = 1'b0;
        wait_o    = 1'b0;
        illegal_o = 1'b0;
        case (opcode)
            OP_NOP:
            begin
                wen_o = 1'b0;
            end
            OP_ADD:
            begin
                wen_o   = 1'b1;
                wdata_o = id_rd_val_i + id_rs_val_i;
            end
            OP_SUB:
            begin
                wen_o   = 1'b1;
                wdata_o = id_rd_val_i - id_rs_val_i;
            end
            OP_AND:
            begin
                wen_o   = 1'b1;
                wdata_o = id_rd_val_i & id_rs_val_i;
            end
            OP_OR:
            begin
                wen_o   = 1'b1;
                wdata_o = id_rd_val_i | id_rs_val_i;
            end
            OP_MOVI:
            begin
                // Zero-extended immediate
                wen_o   = 1'b1;
                wdata_o = DATA_W'(imm);
            end
            // Branches test the rd value
            OP_BEQZ: branch_o = (id_rd_val_i == '0);
            OP_BNEZ: branch_o = (id_rd_val_i != '0);
            OP_SW:   store_o  = 1'b1;
            OP_WAIT: wait_o   = 1'b1;
            default:
            begin
                // Encodings 10 to 15
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

//--- src/core.sv
module core #(
    parameter logic [core_pkg::ID_W-1:0] CORE_ID = '0
)
(
    input  logic                        clk,
    input  logic                        n_reset,

    // Network packet, one per cycle
    input  logic [core_pkg::ID_W-1:0]   net_id_i,
    input  core_pkg::net_op_e           net_op_i,
    input  logic [core_pkg::PC_W-1:0]   net_addr_i,
    input  logic [core_pkg::DATA_W-1:0] net_data_i,

    // Store strobe
    output logic                        store_o,
    output logic [core_pkg::DATA_W-1:0] store_addr_o,
    output logic [core_pkg::DATA_W-1:0] store_data_o,

    output logic                        exception_o
);
    import core_pkg::*;

    // Control strobes
    logic                run;
    logic                pc_load;
    logic                imem_wen;
    logic                net_rf_wen;

    // IF/ID outputs
    logic [INSTR_W-1:0]  if_instr;
    logic [PC_W-1:0]     if_pc;

    // Register file read side
    logic [REG_AW-1:0]   rs_addr;
    logic [REG_AW-1:0]   rd_addr;
    logic [DATA_W-1:0]   rs_val;
    logic [DATA_W-1:0]   rd_val;

    // ID/EX outputs
    logic [INSTR_W-1:0]  id_instr;
    logic [PC_W-1:0]     id_pc;
    logic [DATA_W-1:0]   id_rs_val;
    logic [DATA_W-1:0]   id_rd_val;

    // Execute results
    logic                ex_wen;
    logic [REG_AW-1:0]   ex_waddr;
    logic [DATA_W-1:0]   ex_wdata;
    logic                branch;
    logic [PC_W-1:0]     branch_target;
    logic                ex_wait;
    logic                illegal;

    // ******************************
    // Control
    // ******************************

    core_ctrl #(
        .CORE_ID(CORE_ID)
    ) ctrl_i (
        .clk         (clk),
        .n_reset     (n_reset),
        .net_id_i    (net_id_i),
        .net_op_i    (net_op_i),
        .wait_i      (ex_wait),
        .illegal_i   (illegal),
        .run_o       (run),
        .pc_load_o   (pc_load),
        .imem_wen_o  (imem_wen),
        .net_rf_wen_o(net_rf_wen),
        .exception_o (exception_o)
    );

    // ******************************
    // Pipeline
    // ******************************

    fetch fetch_i (
        .clk            (clk),
        .n_reset        (n_reset),
        .run_i          (run),
        .pc_load_i      (pc_load),
        .imem_wen_i     (imem_wen),
        .net_addr_i     (net_addr_i),
        .net_data_i     (net_data_i),
        .branch_i       (branch),
        .branch_target_i(branch_target),
        .if_instr_o     (if_instr),
        .if_pc_o        (if_pc)
    );

    // Network writes use the low address bits only
    reg_file rf_i (
        .clk       (clk),
        .rs_addr_i (rs_addr),
        .rd_addr_i (rd_addr),
        .net_wen_i (net_rf_wen),
        .net_addr_i(net_addr_i[REG_AW-1:0]),
        .net_data_i(net_data_i),
        .ex_wen_i  (ex_wen),
        .ex_waddr_i(ex_waddr),
        .ex_wdata_i(ex_wdata),
        .rs_val_o  (rs_val),
        .rd_val_o  (rd_val)
    );

    decode_stage decode_i (
        .clk        (clk),
        .n_reset    (n_reset),
        .run_i      (run),
        .branch_i   (branch),
        .if_instr_i (if_instr),
        .if_pc_i    (if_pc),
        .rs_val_i   (rs_val),
        .rd_val_i   (rd_val),
        .ex_wen_i   (ex_wen),
        .ex_waddr_i (ex_waddr),
        .ex_wdata_i (ex_wdata),
        .rs_addr_o  (rs_addr),
        .rd_addr_o  (rd_addr),
        .id_instr_o (id_instr),
        .id_pc_o    (id_pc),
        .id_rs_val_o(id_rs_val),
        .id_rd_val_o(id_rd_val)
    );

    exec_stage exec_i (
        .id_instr_i     (id_instr),
        .id_pc_i        (id_pc),
        .id_rs_val_i    (id_rs_val),
        .id_rd_val_i    (id_rd_val),
        .wen_o          (ex_wen),
        .waddr_o        (ex_waddr),
        .wdata_o        (ex_wdata),
        .branch_o       (branch),
        .branch_target_o(branch_target),
        .store_o        (store_o),
        .store_addr_o   (store_addr_o),
        .store_data_o   (store_data_o),
        .wait_o         (ex_wait),
        .illegal_o      (illegal)
    );

endmodule

//--- sim/core_tb.sv
module core_tb;
    import core_pkg::*;

    localparam logic [ID_W-1:0] TB_CORE_ID = 4'd3;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 20;
    localparam int STORE_TIMEOUT = 300;

    logic              clk;
    logic              n_reset;
    logic [ID_W-1:0]   net_id;
    net_op_e           net_op;
    logic [PC_W-1:0]   net_addr;
    logic [DATA_W-1:0] net_data;
    logic              store;
    logic [DATA_W-1:0] store_addr;
    logic [DATA_W-1:0] store_data;
    logic              exception;

    // Bookkeeping
    int    errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    string test_name;
    logic  in_test;

    core #(
        .CORE_ID(TB_CORE_ID)
    ) core_i (
        .clk         (clk),
        .n_reset     (n_reset),
        .net_id_i    (net_id),
        .net_op_i    (net_op),
        .net_addr_i  (net_addr),
        .net_data_i  (net_data),
        .store_o     (store),
        .store_addr_o(store_addr),
        .store_data_o(store_data),
        .exception_o (exception)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ******************************
    // Stimulus helpers
    // ******************************

    // No packet on the network
    task automatic park_network();
        net_id   = '0;
        net_op   = NET_NONE;
        net_addr = '0;
        net_data = '0;
    endtask

    // One idle cycle in which no store is expected
    task automatic quiet_cycle();
        @(negedge clk);
        if (store)
        begin
            $display("t=%0t unexpected store to %h with data %h in test %s",
                     $time, store_addr, store_data, test_name);
            test_errors++;
        end
        park_network();
    endtask

    task automatic reset_dut();
        @(negedge clk);
        n_reset = 1'b0;
        park_network();
        repeat (RESET_CYCLES) @(negedge clk);
        n_reset = 1'b1;
    endtask

    // Packet held for one cycle after a random gap
    task automatic send_packet(input logic [31:0] id, input logic [31:0] op,
                               input logic [31:0] addr, input logic [31:0] data);
        int gap;
        gap = $urandom % 4;
        repeat (gap) quiet_cycle();
        quiet_cycle();
        net_id   = id[ID_W-1:0];
        net_op   = net_op_e'(op[1:0]);
        net_addr = addr[PC_W-1:0];
        net_data = data;
    endtask

    task automatic expect_store(input logic [31:0] exp_addr, input logic [31:0] exp_data);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < STORE_TIMEOUT)
        begin
            @(negedge clk);
            park_network();
            cycles++;
            if (store)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("Timeout after %0d cycles waiting for a store in test %s",
                     STORE_TIMEOUT, test_name);
            test_errors++;
        end
        else
        begin
            if (store_addr !== exp_addr)
            begin
                $display("[FAIL] t=%0t store_addr_o expected %h got %h",
                         $time, exp_addr, store_addr);
                test_errors++;
            end
            if (store_data !== exp_data)
            begin
                $display("[FAIL] t=%0t store_data_o expected %h got %h",
                         $time, exp_data, store_data);
                test_errors++;
            end
        end
    endtask

    // Exception is a level sampled once the core has settled
    task automatic check_exception(input logic [31:0] exp);
        repeat (IDLE_CYCLES) quiet_cycle();
        if (exception !== exp[0])
        begin
            $display("[FAIL] t=%0t exception_o expected %b got %b",
                     $time, exp[0], exception);
            test_errors++;
        end
    endtask

    // Record with missing fields
    task automatic reject_record(input string text);
        $display("Malformed record in test file: %s", text);
        errors++;
    endtask

    // ******************************
    // Test bookkeeping
    // ******************************

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
        begin
            $display("test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
        errors  += test_errors;
        in_test  = 1'b0;
    endtask

    task automatic start_test(input string name);
        if (in_test)
            finish_test();
        test_name   = name;
        test_errors = 0;
        in_test     = 1'b1;
        reset_dut();
    endtask

    // Drop the line ending left by $fgets
    function automatic string strip_eol(input string text);
        string s;
        s = text;
        while (s.len() > 0 && (s.getc(s.len() - 1) == 8'h0a || s.getc(s.len() - 1) == 8'h0d))
            s = s.substr(0, s.len() - 2);
        return s;
    endfunction

    // ******************************
    // Main sequence
    // ******************************

    initial
    begin
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;

        n_reset = 1'b0;
        park_network();
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "none";
        in_test      = 1'b0;
        // Fixed seed for the packet gaps
        void'($urandom(1));

        fd = $fopen("sim/core_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open sim/core_tests.txt");
            $display("Some tests failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                line = strip_eol(line);
                // Blank lines and comments carry no record
                if (line.len() > 0 && line.getc(0) != "#")
                begin
                    kind = line.getc(0);
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    f4 = '0;
                    case (kind)
                        "T": start_test(line.substr(2, line.len() - 1));
                        "P":
                        begin
                            n = $sscanf(line, "P %h %h %h %h", f1, f2, f3, f4);
                            if (n != 4)
                                reject_record(line);
                            else
                                send_packet(f1, f2, f3, f4);
                        end
                        "E":
                        begin
                            n = $sscanf(line, "E %h %h", f1, f2);
                            if (n != 2)
                                reject_record(line);
                            else
                                expect_store(f1, f2);
                        end
                        "X":
                        begin
                            n = $sscanf(line, "X %h", f1);
                            if (n != 1)
                                reject_record(line);
                            else
                                check_exception(f1);
                        end
                        "D": finish_test();
                        default:
                        begin
                            $display("Unknown record in test file: %s", line);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (in_test)
                finish_test();

            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
            if (errors == 0 && tests_run > 0)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

//--- tb.f
src/core_pkg.sv
src/core_ctrl.sv
src/fetch.sv
src/reg_file.sv
src/decode_stage.sv
src/exec_stage.sv
src/core.sv
sim/core_tb.sv

//--- Bender.yml
package:
  name: core

sources:
  - files:
      - src/core_pkg.sv
      - src/core_ctrl.sv
      - src/fetch.sv
      - src/reg_file.sv
      - src/decode_stage.sv
      - src/exec_stage.sv
      - src/core.sv
  - target: simulation
    files:
      - sim/core_tb.sv

//--- sim/core_tests.txt
# T name | P id op addr data | E store_addr store_data | X exception | D
# All fields hex, op 1 = PC, 2 = INSTR, 3 = REG
T reset_idle
X 0
D
T alu_forward
P 3 3 01 00000035
P 3 3 02 0000000f
P 3 2 00 00001102
P 3 2 01 00002201
P 3 2 02 00003102
P 3 2 03 00005307
P 3 2 04 00004301
P 3 2 05 00008301
P 3 2 06 00008200
P 3 2 07 00009000
P 3 1 00 00000000
E 00000040 00000047
E 00000000 ffffffcb
D
T branches
P 3 2 20 00006003
P 3 2 21 00008000
P 3 2 22 00008000
P 3 2 23 00007002
P 3 2 24 00005377
P 3 2 25 00007303
P 3 2 26 00008000
P 3 2 27 00008000
P 3 2 28 00006304
P 3 2 29 00008333
P 3 2 2a 00009000
P 3 1 20 00000000
E 00000077 00000077
D
T foreign_id
P 3 3 07 00001234
P 3 2 40 00008707
P 3 2 41 00009000
P 5 3 07 0000ffff
P 5 2 40 00009000
P 5 1 40 00000000
P 3 1 40 00000000
E 00001234 00001234
D
T wait_restart
P 3 2 60 00005911
P 3 2 61 00008999
P 3 2 62 00009000
P 3 2 70 00005922
P 3 2 71 00001999
P 3 2 72 00008999
P 3 2 73 00009000
P 3 1 60 00000000
E 00000011 00000011
X 0
P 3 1 70 00000000
E 00000044 00000044
X 0
D
T pc_while_running
P 3 2 80 00006000
P 3 1 80 00000000
P 3 1 80 00000000
X 1
D
T illegal_opcode
P 3 2 90 00005a05
P 3 2 91 00008aaa
P 3 2 92 0000a000
P 3 2 93 00008aaa
P 3 1 90 00000000
E 00000005 00000005
X 1
P 3 1 90 00000000
X 1
D
